/* hw/fabric_cfg_pkg.sv */
package fabric_cfg_pkg;

	// the tile number forms the low half of a configuration address.
	typedef logic [15:0] tile_id_t;

	typedef logic [31:0] cfg_data_t;

	// the block code forms the high half of a configuration address.
	typedef enum logic [15:0] {
		CFG_CLB = 16'd4,
		CFG_CB1 = 16'd5,
		CFG_CB0 = 16'd6,
		CFG_SB  = 16'd7
	} block_sel_e;

	typedef enum logic [1:0] {
		OP_AND     = 2'd0,
		OP_OR      = 2'd1,
		OP_XOR     = 2'd2,
		OP_XOR_REG = 2'd3
	} clb_op_e;

	// Single-cycle write strobe. It is broadcast to every tile and has no back-pressure.
	typedef struct packed {
		logic       valid;
		tile_id_t   tile;
		block_sel_e block;
		cfg_data_t  data;
	} cfg_write_t;

endpackage

/* hw/fabric_route_pkg.sv */
package fabric_route_pkg;

	typedef logic [3:0] track_bus_t; // four tracks of one side in one direction.

	// side numbering is 0 north, 1 east, 2 south, 3 west.
	typedef logic [1:0] side_idx_t;
	typedef logic [1:0] track_idx_t;

	// codes 0 to 2 take the same track from the other sides in rising side order.
	// Code 3 takes the logic block output.
	typedef logic [1:0] route_sel_t;

	typedef logic [2:0] cb_sel_t; // picks one of eight tracks in a connect box.

	typedef struct packed {
		track_bus_t north;
		track_bus_t east;
		track_bus_t south;
		track_bus_t west;
	} tile_side_t;

	typedef struct packed {
		track_bus_t t0_north;
		track_bus_t t0_south;
		track_bus_t t0_west;
		track_bus_t t1_north;
		track_bus_t t1_south;
		track_bus_t t1_east;
	} fabric_edge_t;

endpackage

/* hw/connect_box.sv */
`timescale 1ns/1ps

module connect_box (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      config_en,
	input  fabric_cfg_pkg::cfg_data_t config_data,
	input  logic [7:0]                tracks,
	output logic                      block_out
);

	fabric_route_pkg::cb_sel_t sel_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q <= config_data[2:0]; // only the low three payload bits are used.
		end
	end

	// tracks 0 to 3 come into the tile and tracks 4 to 7 leave it.
	always_comb begin
		block_out = tracks[sel_q];
	end

endmodule

/* hw/switch_box.sv */
`timescale 1ns/1ps

module switch_box (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         config_en,
	input  fabric_cfg_pkg::cfg_data_t    config_data,
	input  fabric_route_pkg::tile_side_t in_tracks,
	input  logic                         pe_out,
	output fabric_route_pkg::tile_side_t out_tracks
);

	fabric_route_pkg::route_sel_t [3:0][3:0] sel_q; // indexed by side, then track.
	fabric_route_pkg::track_bus_t [3:0]      in_arr;
	fabric_route_pkg::track_bus_t [3:0]      out_arr;
	fabric_route_pkg::side_idx_t             wr_side;
	fabric_route_pkg::track_idx_t            wr_track;
	fabric_route_pkg::route_sel_t            wr_sel;

	// Code c reaches side c below the own side and side c + 1 from there on.
	function automatic fabric_route_pkg::side_idx_t src_side(
		input fabric_route_pkg::side_idx_t  own,
		input fabric_route_pkg::route_sel_t code
	);
		if (code < own) begin
			src_side = code;
		end else begin
			src_side = code + 2'd1;
		end
	endfunction

	assign wr_sel   = config_data[1:0];
	assign wr_side  = config_data[3:2];
	assign wr_track = config_data[5:4];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sel_q <= '0;
		end else if (config_en) begin
			sel_q[wr_side][wr_track] <= wr_sel; // the other fifteen selects keep their value.
		end
	end

	always_comb begin
		in_arr[0] = in_tracks.north;
		in_arr[1] = in_tracks.east;
		in_arr[2] = in_tracks.south;
		in_arr[3] = in_tracks.west;
	end

	always_comb begin
		fabric_route_pkg::side_idx_t src;
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				src = src_side(fabric_route_pkg::side_idx_t'(s), sel_q[s][t]);
				if (sel_q[s][t] == 2'd3) begin
					out_arr[s][t] = pe_out;
				end else begin
					out_arr[s][t] = in_arr[src][t];
				end
			end
		end
	end

	assign out_tracks.north = out_arr[0];
	assign out_tracks.east  = out_arr[1];
	assign out_tracks.south = out_arr[2];
	assign out_tracks.west  = out_arr[3];

endmodule

/* hw/clb.sv */
`timescale 1ns/1ps

module clb (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      config_en,
	input  fabric_cfg_pkg::cfg_data_t config_data,
	input  logic                      in0,
	input  logic                      in1,
	output logic                      out
);

	fabric_cfg_pkg::clb_op_e op_q;
	logic                    xor_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			op_q <= fabric_cfg_pkg::OP_AND;
		end else if (config_en) begin
			op_q <= fabric_cfg_pkg::clb_op_e'(config_data[1:0]);
		end
	end

	// runs on every edge so the registered mode sees the previous cycle at once.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			xor_q <= 1'b0;
		end else begin
			xor_q <= in0 ^ in1;
		end
	end

	always_comb begin
		case (op_q)
			fabric_cfg_pkg::OP_AND:     out = in0 & in1;
			fabric_cfg_pkg::OP_OR:      out = in0 | in1;
			fabric_cfg_pkg::OP_XOR:     out = in0 ^ in1;
			fabric_cfg_pkg::OP_XOR_REG: out = xor_q;
			default:                    out = 1'b0;
		endcase
	end

endmodule

/* hw/pe_tile.sv */
`timescale 1ns/1ps

module pe_tile #(
	parameter fabric_cfg_pkg::tile_id_t TILE_ID = 16'h0010
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  fabric_cfg_pkg::cfg_write_t   cfg,
	input  fabric_route_pkg::tile_side_t in_tracks,
	output fabric_route_pkg::tile_side_t out_tracks
);

	logic       tile_hit;
	logic       config_en_sb;
	logic       config_en_cb0;
	logic       config_en_cb1;
	logic       config_en_clb;
	logic       op_0;
	logic       op_1;
	logic       pe_out;
	logic [7:0] cb0_tracks;
	logic [7:0] cb1_tracks;

	assign tile_hit = cfg.valid && (cfg.tile == TILE_ID);

	always_comb begin
		config_en_sb  = 1'b0;
		config_en_cb0 = 1'b0;
		config_en_cb1 = 1'b0;
		config_en_clb = 1'b0;
		if (tile_hit) begin
			case (cfg.block)
				fabric_cfg_pkg::CFG_SB:  config_en_sb  = 1'b1;
				fabric_cfg_pkg::CFG_CB0: config_en_cb0 = 1'b1;
				fabric_cfg_pkg::CFG_CB1: config_en_cb1 = 1'b1;
				fabric_cfg_pkg::CFG_CLB: config_en_clb = 1'b1;
				default: ; // unknown block codes are dropped.
			endcase
		end
	end

	assign cb0_tracks = {out_tracks.north, in_tracks.north}; // incoming tracks sit in the low half.
	assign cb1_tracks = {out_tracks.east, in_tracks.east};

	connect_box cb0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_cb0),
		.config_data (cfg.data),
		.tracks      (cb0_tracks),
		.block_out   (op_0)
	);

	connect_box cb1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_cb1),
		.config_data (cfg.data),
		.tracks      (cb1_tracks),
		.block_out   (op_1)
	);

	switch_box sb (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_sb),
		.config_data (cfg.data),
		.in_tracks   (in_tracks),
		.pe_out      (pe_out),
		.out_tracks  (out_tracks)
	);

	clb compute_block (
		.clk         (clk),
		.rst_n       (rst_n),
		.config_en   (config_en_clb),
		.config_data (cfg.data),
		.in0         (op_0),
		.in1         (op_1),
		.out         (pe_out)
	);

endmodule

/* hw/fabric_top.sv */
`timescale 1ns/1ps

module fabric_top #(
	parameter fabric_cfg_pkg::tile_id_t TILE_ID_BASE = 16'h0010
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  fabric_cfg_pkg::cfg_write_t     cfg,
	input  fabric_route_pkg::fabric_edge_t edge_in,
	output fabric_route_pkg::fabric_edge_t edge_out
);

	localparam fabric_cfg_pkg::tile_id_t TILE1_ID = TILE_ID_BASE + 16'd1;

	fabric_route_pkg::tile_side_t t0_in;
	fabric_route_pkg::tile_side_t t0_out;
	fabric_route_pkg::tile_side_t t1_in;
	fabric_route_pkg::tile_side_t t1_out;

	assign t0_in.north = edge_in.t0_north;
	assign t0_in.east  = t1_out.west; // the east-west link between the two tiles.
	assign t0_in.south = edge_in.t0_south;
	assign t0_in.west  = edge_in.t0_west;

	assign t1_in.north = edge_in.t1_north;
	assign t1_in.east  = edge_in.t1_east;
	assign t1_in.south = edge_in.t1_south;
	assign t1_in.west  = t0_out.east;

	assign edge_out.t0_north = t0_out.north;
	assign edge_out.t0_south = t0_out.south;
	assign edge_out.t0_west  = t0_out.west;
	assign edge_out.t1_north = t1_out.north;
	assign edge_out.t1_south = t1_out.south;
	assign edge_out.t1_east  = t1_out.east;

	pe_tile #(
		.TILE_ID (TILE_ID_BASE)
	) tile0_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.in_tracks  (t0_in),
		.out_tracks (t0_out)
	);

	pe_tile #(
		.TILE_ID (TILE1_ID)
	) tile1_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.cfg        (cfg),
		.in_tracks  (t1_in),
		.out_tracks (t1_out)
	);

endmodule

/* tests/fabric_props.sv */
`timescale 1ns/1ps

module fabric_props #(
	parameter fabric_cfg_pkg::tile_id_t TILE_ID = 16'h0010
) (
	input logic                         clk,
	input logic                         rst_n,
	input fabric_cfg_pkg::cfg_write_t   cfg,
	input fabric_route_pkg::tile_side_t in_tracks,
	input fabric_route_pkg::tile_side_t out_tracks,
	input logic                         pe_out
);

	fabric_route_pkg::route_sel_t [3:0][3:0] sb_shadow; // side, then track.
	fabric_route_pkg::cb_sel_t               cb0_shadow;
	fabric_route_pkg::cb_sel_t               cb1_shadow;
	fabric_cfg_pkg::clb_op_e                 op_shadow;
	fabric_route_pkg::track_bus_t [3:0]      side_in;
	fabric_route_pkg::track_bus_t [3:0]      exp_arr;
	fabric_route_pkg::tile_side_t            exp_out;
	logic [7:0]                              cb0_view;
	logic [7:0]                              cb1_view;
	logic                                    op0_exp;
	logic                                    op1_exp;
	logic                                    comb_exp;
	logic                                    failed = 1'b0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sb_shadow  <= '0;
			cb0_shadow <= '0;
			cb1_shadow <= '0;
			op_shadow  <= fabric_cfg_pkg::OP_AND;
		end else if (cfg.valid && cfg.tile == TILE_ID) begin
			case (cfg.block)
				fabric_cfg_pkg::CFG_SB:  sb_shadow[cfg.data[3:2]][cfg.data[5:4]] <= cfg.data[1:0];
				fabric_cfg_pkg::CFG_CB0: cb0_shadow <= cfg.data[2:0];
				fabric_cfg_pkg::CFG_CB1: cb1_shadow <= cfg.data[2:0];
				fabric_cfg_pkg::CFG_CLB: op_shadow <= fabric_cfg_pkg::clb_op_e'(cfg.data[1:0]);
				default: ;
			endcase
		end
	end

	// the code counts through the other sides in order; no match means the logic block.
	always_comb begin
		int n;
		side_in = {in_tracks.west, in_tracks.south, in_tracks.east, in_tracks.north};
		for (int s = 0; s < 4; s++) begin
			for (int t = 0; t < 4; t++) begin
				exp_arr[s][t] = pe_out;
				n = 0;
				for (int o = 0; o < 4; o++) begin
					if (o != s) begin
						if (n == sb_shadow[s][t]) begin
							exp_arr[s][t] = side_in[o][t];
						end
						n++;
					end
				end
			end
		end
		exp_out = {exp_arr[0], exp_arr[1], exp_arr[2], exp_arr[3]};
	end

	always_comb begin
		cb0_view = {out_tracks.north, in_tracks.north};
		cb1_view = {out_tracks.east, in_tracks.east};
		op0_exp  = cb0_view[cb0_shadow];
		op1_exp  = cb1_view[cb1_shadow];
		case (op_shadow)
			fabric_cfg_pkg::OP_AND: comb_exp = op0_exp & op1_exp;
			fabric_cfg_pkg::OP_OR:  comb_exp = op0_exp | op1_exp;
			fabric_cfg_pkg::OP_XOR: comb_exp = op0_exp ^ op1_exp;
			default:                comb_exp = 1'b0;
		endcase
	end

	a_routing: assert property (@(posedge clk) disable iff (!rst_n) out_tracks == exp_out)
		else begin
			failed = 1'b1;
			$error("switch box outputs differ from the shadow configuration");
		end

	a_comb_op: assert property (@(posedge clk) disable iff (!rst_n)
		(op_shadow != fabric_cfg_pkg::OP_XOR_REG) |-> (pe_out == comb_exp))
		else begin
			failed = 1'b1;
			$error("combinational logic block output is wrong");
		end

	a_reg_op: assert property (@(posedge clk) disable iff (!rst_n)
		(op_shadow == fabric_cfg_pkg::OP_XOR_REG && $past(rst_n)) |->
		(pe_out == $past(op0_exp ^ op1_exp)))
		else begin
			failed = 1'b1;
			$error("registered xor output does not match the previous operands");
		end

endmodule

bind pe_tile fabric_props #(
	.TILE_ID (TILE_ID)
) props_i (
	.clk        (clk),
	.rst_n      (rst_n),
	.cfg        (cfg),
	.in_tracks  (in_tracks),
	.out_tracks (out_tracks),
	.pe_out     (pe_out)
);

/* tests/fabric_tb.sv */
`timescale 1ns/1ps

module fabric_tb;

	localparam fabric_cfg_pkg::tile_id_t TILE0 = 16'h0010;
	localparam fabric_cfg_pkg::tile_id_t TILE1 = 16'h0011;
	localparam int MAX_CYCLES = 2000; // about three times the length of the test sequence.

	logic                           clk;
	logic                           rst_n;
	fabric_cfg_pkg::cfg_write_t     cfg;
	fabric_route_pkg::fabric_edge_t edge_in;
	fabric_route_pkg::fabric_edge_t edge_out;
	integer                         seed;
	int                             cycles = 0;

	fabric_top dut_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.cfg      (cfg),
		.edge_in  (edge_in),
		.edge_out (edge_out)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the test sequence did not finish within %0d cycles.", MAX_CYCLES);
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	always @(negedge clk) begin
		if (dut_i.tile0_i.props_i.failed || dut_i.tile1_i.props_i.failed) begin
			$display("A bound assertion inside one of the tiles failed.");
			$display("Simulation FAILED");
			$fatal(1);
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic write_cfg(input fabric_cfg_pkg::tile_id_t tile,
		input fabric_cfg_pkg::block_sel_e block, input fabric_cfg_pkg::cfg_data_t data);
		@(posedge clk);
		cfg.valid <= 1'b1;
		cfg.tile  <= tile;
		cfg.block <= block;
		cfg.data  <= data;
	endtask

	// Ends any write strobe and puts fresh random values on the edge inputs.
	task automatic idle_cycle();
		logic [31:0] r;
		@(posedge clk);
		r = $random(seed);
		cfg.valid <= 1'b0;
		edge_in   <= r[23:0];
	endtask

	task automatic check_value(input string name, input logic [3:0] got, input logic [3:0] exp);
		assert (got == exp) else begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("Simulation FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic op_result(input int op, input logic x, input logic y);
		case (op)
			0:       op_result = x & y;
			1:       op_result = x | y;
			default: op_result = x ^ y;
		endcase
	endfunction

	initial begin
		logic [31:0]              r;
		logic [1:0]               a;
		logic [1:0]               b;
		logic [1:0]               k;
		logic                     prev_xor;
		logic [15:0]              code;
		fabric_cfg_pkg::tile_id_t tile;
		seed      = 32'hb34d62d5;
		rst_n     = 1'b0;
		cfg.valid = 1'b0;
		cfg.tile  = '0;
		cfg.block = fabric_cfg_pkg::CFG_SB;
		cfg.data  = '0;
		edge_in   = '0;
		apply_reset();

		// every select is 0 after reset, so each output follows its first other side.
		repeat (40) begin
			idle_cycle();
			@(negedge clk);
			check_value("edge_out.t0_north", edge_out.t0_north, edge_in.t1_north);
			check_value("edge_out.t0_south", edge_out.t0_south, edge_in.t0_north);
			check_value("edge_out.t0_west", edge_out.t0_west, edge_in.t0_north);
			check_value("edge_out.t1_north", edge_out.t1_north, edge_in.t1_east);
			check_value("edge_out.t1_south", edge_out.t1_south, edge_in.t1_north);
			check_value("edge_out.t1_east", edge_out.t1_east, edge_in.t1_north);
		end

		repeat (100) begin
			r = $random(seed);
			if (r[6] && r[3:2] == 2'd3 && r[1:0] == 2'd3) begin
				r[1:0] = 2'd0; // keeps the logic block of tile 1 off its west side.
			end
			write_cfg(r[6] ? TILE1 : TILE0, fabric_cfg_pkg::CFG_SB, {26'd0, r[5:0]});
			idle_cycle();
		end

		apply_reset();
		r = $random(seed);
		k = r[1:0];
		write_cfg(TILE0, fabric_cfg_pkg::CFG_SB, {26'd0, k, 2'd0, 2'd3});
		for (int op = 0; op < 3; op++) begin
			r = $random(seed);
			a = r[1:0];
			b = r[3:2];
			write_cfg(TILE0, fabric_cfg_pkg::CFG_CB0, {30'd0, a});
			write_cfg(TILE0, fabric_cfg_pkg::CFG_CB1, {30'd0, b});
			write_cfg(TILE0, fabric_cfg_pkg::CFG_CLB, 32'(op));
			repeat (30) begin
				idle_cycle();
				@(negedge clk);
				check_value($sformatf("edge_out.t0_north[%0d]", k), edge_out.t0_north[k],
					op_result(op, edge_in.t0_north[a], edge_in.t1_north[b]));
			end
		end

		write_cfg(TILE0, fabric_cfg_pkg::CFG_CLB, 32'd3);
		@(negedge clk);
		prev_xor = edge_in.t0_north[a] ^ edge_in.t1_north[b];
		repeat (40) begin
			idle_cycle();
			@(negedge clk);
			check_value($sformatf("edge_out.t0_north[%0d]", k), edge_out.t0_north[k], prev_xor);
			prev_xor = edge_in.t0_north[a] ^ edge_in.t1_north[b];
		end

		// west edge of tile 0 runs through both east outputs to the east edge of tile 1.
		for (int t = 0; t < 4; t++) begin
			write_cfg(TILE0, fabric_cfg_pkg::CFG_SB, {26'd0, 2'(t), 2'd1, 2'd2});
			write_cfg(TILE1, fabric_cfg_pkg::CFG_SB, {26'd0, 2'(t), 2'd1, 2'd2});
		end
		repeat (40) begin
			idle_cycle();
			@(negedge clk);
			check_value("edge_out.t1_east", edge_out.t1_east, edge_in.t0_west);
		end

		@(negedge clk);
		prev_xor = edge_in.t0_north[a] ^ edge_in.t1_north[b];
		repeat (80) begin
			r    = $random(seed);
			tile = r[31:16];
			code = {12'd0, r[3:0]};
			if (r[4]) begin
				if (tile == TILE0 || tile == TILE1) begin
					tile = 16'h0020;
				end
				write_cfg(tile, fabric_cfg_pkg::block_sel_e'(16'd4 + {14'd0, r[6:5]}), $random(seed));
			end else begin
				if (code >= 16'd4 && code <= 16'd7) begin
					code = code + 16'd8;
				end
				write_cfg(r[7] ? TILE1 : TILE0, fabric_cfg_pkg::block_sel_e'(code), $random(seed));
			end
			idle_cycle();
			@(negedge clk);
			check_value("edge_out.t1_east", edge_out.t1_east, edge_in.t0_west);
			check_value($sformatf("edge_out.t0_north[%0d]", k), edge_out.t0_north[k], prev_xor);
			prev_xor = edge_in.t0_north[a] ^ edge_in.t1_north[b];
		end

		repeat (5) @(posedge clk);
		if (dut_i.tile0_i.props_i.failed || dut_i.tile1_i.props_i.failed) begin
			$display("A bound assertion inside one of the tiles failed.");
			$display("Simulation FAILED");
			$fatal(1);
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

/* compile.f */
hw/fabric_cfg_pkg.sv
hw/fabric_route_pkg.sv
hw/connect_box.sv
hw/switch_box.sv
hw/clb.sv
hw/pe_tile.sv
hw/fabric_top.sv
tests/fabric_props.sv
tests/fabric_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module fabric_tb -f compile.f -o fabric_sim

out=$(./obj_dir/fabric_sim +verilator+error+limit+100 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Simulation PASSED$'; then
	exit 0
fi
exit 1
